// ==== verilog/htu_settings.svh ====
`ifndef HTU_SETTINGS_SVH
`define HTU_SETTINGS_SVH

// tag store geometry
`define HTU_NUM_SETS 8
`define HTU_NUM_WAYS 8

// --------------------------------------------------------------------------
// address field positions
// --------------------------------------------------------------------------
`define HTU_TAG_MSB    31
`define HTU_TAG_LSB    10
`define HTU_BANK_MSB   9
`define HTU_BANK_LSB   8
`define HTU_INDEX_MSB  7
`define HTU_INDEX_LSB  5
`define HTU_OFFSET_BIT 4

// half-line states, 2'b10 unused
`define HTU_ST_EMPTY 2'b00
`define HTU_ST_CLEAN 2'b01
`define HTU_ST_DIRTY 2'b11

`endif

// ==== verilog/htu_pkg.sv ====
package htu_pkg;

  // --------------------------------------------------------------------------
  // request address, bits 31 down to 4
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic [21:0] tag;
    logic [1:0]  bank;
    logic [2:0]  index;
    logic        offset;
  } htu_addr_fields_t;

  typedef struct packed {
    logic [26:0] line;
    logic        offset;
  } htu_addr_line_t;

  // field view for lookup, line view for refill
  typedef union packed {
    htu_addr_fields_t f;
    htu_addr_line_t   l;
  } htu_addr_u;

  // crossbar request
  typedef struct packed {
    logic [1:0] ch_id;
    logic       write;
    htu_addr_u  addr;
    logic [7:0] wbuf_id;
  } htu_req_t;

  // result for the indexed set
  typedef struct packed {
    logic        hit;
    logic [2:0]  way;
    logic        victim_dirty;
    logic [21:0] victim_tag;
    logic [1:0]  off0_state;
    logic [1:0]  off1_state;
  } htu_lookup_t;

  // packet to the issue stage
  typedef struct packed {
    logic [1:0] ch_id;
    logic       write;
    logic       need_evict;
    logic       need_linefill;
    logic [2:0] set;
    logic [2:0] way;
    logic       offset;
    logic [7:0] wbuf_id;
    logic [1:0] off0_state;
    logic [1:0] off1_state;
  } htu_issue_t;

  // shared by the ar and aw channels
  typedef struct packed {
    logic [2:0]  set;
    logic [2:0]  way;
    logic [26:0] araddr;
    logic [26:0] awaddr;
  } htu_bus_req_t;

endpackage

// ==== verilog/htu_set_entry.sv ====
`timescale 1ns/10ps
`include "htu_settings.svh"

module htu_set_entry import htu_pkg::*; (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        update_i,
  input  htu_req_t    req_i,
  output htu_lookup_t lookup_o
);

  localparam int NUM_WAYS = `HTU_NUM_WAYS;
  localparam int TAG_W    = `HTU_TAG_MSB - `HTU_TAG_LSB + 1;
  localparam int WAY_W    = $clog2(NUM_WAYS);

  logic [TAG_W-1:0] tag_q  [NUM_WAYS];
  logic [1:0]       off0_q [NUM_WAYS];
  logic [1:0]       off1_q [NUM_WAYS];
  logic [WAY_W-1:0] rr_ptr_q;

  logic [NUM_WAYS-1:0] way_hit;
  logic                hit;
  logic [WAY_W-1:0]    hit_way;
  logic [WAY_W-1:0]    access_way;
  logic [1:0]          acc_state;
  logic [1:0]          new_state;

  // --------------------------------------------------------------------------
  // tag compare
  // --------------------------------------------------------------------------
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      way_hit[w] = ((off0_q[w] != `HTU_ST_EMPTY) || (off1_q[w] != `HTU_ST_EMPTY))
                 && (tag_q[w] == req_i.addr.f.tag);
    end
  end

  assign hit = |way_hit;

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (way_hit[w]) begin
        hit_way = WAY_W'(w);
      end
    end
  end

  // miss goes to the way under the pointer
  assign access_way = hit ? hit_way : rr_ptr_q;

  assign acc_state = req_i.addr.f.offset ? off1_q[access_way] : off0_q[access_way];

  always_comb begin
    if (req_i.write) begin
      new_state = `HTU_ST_DIRTY;
    end else if (!hit || acc_state == `HTU_ST_EMPTY) begin
      new_state = `HTU_ST_CLEAN;
    end else begin
      new_state = acc_state;
    end
  end

  assign lookup_o.hit          = hit;
  assign lookup_o.way          = access_way;
  assign lookup_o.victim_dirty = (off0_q[rr_ptr_q] == `HTU_ST_DIRTY)
                               || (off1_q[rr_ptr_q] == `HTU_ST_DIRTY);
  assign lookup_o.victim_tag   = tag_q[rr_ptr_q];
  assign lookup_o.off0_state   = off0_q[access_way];
  assign lookup_o.off1_state   = off1_q[access_way];

  // --------------------------------------------------------------------------
  // state update
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        off0_q[w] <= `HTU_ST_EMPTY;
        off1_q[w] <= `HTU_ST_EMPTY;
      end
      rr_ptr_q <= '0;
    end else if (update_i) begin
      if (req_i.addr.f.offset) begin
        off1_q[access_way] <= new_state;
        if (!hit) begin
          off0_q[access_way] <= `HTU_ST_EMPTY;
        end
      end else begin
        off0_q[access_way] <= new_state;
        if (!hit) begin
          off1_q[access_way] <= `HTU_ST_EMPTY;
        end
      end
      // wraps modulo way count
      if (!hit) begin
        rr_ptr_q <= rr_ptr_q + 1'b1;
      end
    end
  end

  // new tag on allocation
  always_ff @(posedge clk_i) begin
    if (update_i && !hit) begin
      tag_q[rr_ptr_q] <= req_i.addr.f.tag;
    end
  end

  // a tag is only allocated on a miss, so it never lives in two ways
  a_single_hit : assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(way_hit));

endmodule

// ==== verilog/htu_set_array.sv ====
`timescale 1ns/10ps
`include "htu_settings.svh"

module htu_set_array import htu_pkg::*; (
  input  logic        clk_i,
  input  logic        reset_i,
  input  htu_req_t    req_i,
  input  logic        kickoff_i,
  output htu_lookup_t lookup_o
);

  localparam int NUM_SETS = `HTU_NUM_SETS;
  localparam int IDX_W    = `HTU_INDEX_MSB - `HTU_INDEX_LSB + 1;
  localparam int LK_W     = $bits(htu_lookup_t);

  logic [NUM_SETS-1:0] set_sel;
  logic [NUM_SETS-1:0] set_upd;
  htu_lookup_t         set_lookup [NUM_SETS];
  logic [LK_W-1:0]     merged;

  // index decode
  always_comb begin
    for (int s = 0; s < NUM_SETS; s++) begin
      set_sel[s] = (req_i.addr.f.index == IDX_W'(s));
    end
  end

  assign set_upd = set_sel & {NUM_SETS{kickoff_i}};

  // --------------------------------------------------------------------------
  // set entries
  // --------------------------------------------------------------------------
  for (genvar s = 0; s < NUM_SETS; s++) begin : g_set
    htu_set_entry u_set_entry (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .update_i (set_upd[s]),
      .req_i    (req_i),
      .lookup_o (set_lookup[s])
    );
  end

  // and-or select on the one-hot index
  always_comb begin
    merged = '0;
    for (int s = 0; s < NUM_SETS; s++) begin
      merged = merged | ({LK_W{set_sel[s]}} & set_lookup[s]);
    end
  end

  assign lookup_o = merged;

  // exactly one set is updated per kickoff
  a_sel_onehot : assert property (@(posedge clk_i) disable iff (reset_i)
    kickoff_i |-> $onehot(set_upd));

endmodule

// ==== verilog/htu_ctrl.sv ====
`timescale 1ns/10ps
`include "htu_settings.svh"

module htu_ctrl import htu_pkg::*; (
  input  logic         clk_i,
  input  logic         reset_i,
  // crossbar
  input  logic         req_valid_i,
  input  htu_req_t     req_i,
  output logic         req_allow_in_o,
  // issue stage
  output logic         issue_valid_o,
  output htu_issue_t   issue_o,
  input  logic         issue_allow_in_i,
  // bus interface
  output logic         ar_valid_o,
  output logic         aw_valid_o,
  output htu_bus_req_t bus_req_o,
  input  logic         bus_allow_in_i,
  // set array
  input  htu_lookup_t  lookup_i,
  output logic         kickoff_o
);

  logic [1:0] acc_state;
  logic       need_linefill;
  logic       need_evict;
  logic       need_bus;
  logic       bus_ok;

  // --------------------------------------------------------------------------
  // linefill and eviction
  // --------------------------------------------------------------------------
  assign acc_state = req_i.addr.f.offset ? lookup_i.off1_state : lookup_i.off0_state;

  // read miss, or hit on an empty half
  assign need_linefill = !req_i.write
                       && (!lookup_i.hit || acc_state == `HTU_ST_EMPTY);

  assign need_evict = !lookup_i.hit && lookup_i.victim_dirty;

  assign need_bus = need_linefill || need_evict;
  assign bus_ok   = !need_bus || bus_allow_in_i;

  // --------------------------------------------------------------------------
  // handshakes
  // --------------------------------------------------------------------------
  assign req_allow_in_o = issue_allow_in_i && bus_ok;
  assign issue_valid_o  = req_valid_i && bus_ok;
  assign kickoff_o      = req_valid_i && req_allow_in_o;

  assign ar_valid_o = req_valid_i && need_linefill && issue_allow_in_i;
  assign aw_valid_o = req_valid_i && need_evict && issue_allow_in_i;

  // issue packet
  assign issue_o.ch_id         = req_i.ch_id;
  assign issue_o.write         = req_i.write;
  assign issue_o.need_evict    = need_evict;
  assign issue_o.need_linefill = need_linefill;
  assign issue_o.set           = req_i.addr.f.index;
  assign issue_o.way           = lookup_i.way;
  assign issue_o.offset        = req_i.addr.f.offset;
  assign issue_o.wbuf_id       = req_i.wbuf_id;
  assign issue_o.off0_state    = lookup_i.off0_state;
  assign issue_o.off1_state    = lookup_i.off1_state;

  // bus request
  assign bus_req_o.set    = req_i.addr.f.index;
  assign bus_req_o.way    = lookup_i.way;
  assign bus_req_o.araddr = req_i.addr.l.line;
  assign bus_req_o.awaddr = {lookup_i.victim_tag, req_i.addr.f.bank, req_i.addr.f.index};

  // no bus request slips past a stalled issue stage
  a_bus_needs_issue : assert property (@(posedge clk_i) disable iff (reset_i)
    (ar_valid_o || aw_valid_o) |-> issue_allow_in_i);

  // kickoff only with a valid request that the issue stage takes
  a_kickoff_valid : assert property (@(posedge clk_i) disable iff (reset_i)
    kickoff_o |-> (req_valid_i && issue_valid_o && issue_allow_in_i));

endmodule

// ==== verilog/htu_top.sv ====
`timescale 1ns/10ps

module htu_top import htu_pkg::*; (
  input  logic         clk_i,
  input  logic         reset_i,
  // crossbar
  input  logic         req_valid_i,
  input  htu_req_t     req_i,
  output logic         req_allow_in_o,
  // issue stage
  output logic         issue_valid_o,
  output htu_issue_t   issue_o,
  input  logic         issue_allow_in_i,
  // bus interface
  output logic         ar_valid_o,
  output logic         aw_valid_o,
  output htu_bus_req_t bus_req_o,
  input  logic         bus_allow_in_i
);

  htu_lookup_t lookup;
  logic        kickoff;

  // --------------------------------------------------------------------------
  // control
  // --------------------------------------------------------------------------
  htu_ctrl u_ctrl (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .req_valid_i      (req_valid_i),
    .req_i            (req_i),
    .req_allow_in_o   (req_allow_in_o),
    .issue_valid_o    (issue_valid_o),
    .issue_o          (issue_o),
    .issue_allow_in_i (issue_allow_in_i),
    .ar_valid_o       (ar_valid_o),
    .aw_valid_o       (aw_valid_o),
    .bus_req_o        (bus_req_o),
    .bus_allow_in_i   (bus_allow_in_i),
    .lookup_i         (lookup),
    .kickoff_o        (kickoff)
  );

  // tag store
  htu_set_array u_set_array (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .req_i     (req_i),
    .kickoff_i (kickoff),
    .lookup_o  (lookup)
  );

endmodule

// ==== dv/htu_tb_model.svh ====
`ifndef HTU_TB_MODEL_SVH
`define HTU_TB_MODEL_SVH

// reference copy of the tag store
logic [21:0] m_tag  [`HTU_NUM_SETS][`HTU_NUM_WAYS];
logic [1:0]  m_half [`HTU_NUM_SETS][`HTU_NUM_WAYS][2];
int          m_ptr  [`HTU_NUM_SETS];

function automatic void model_reset();
  for (int s = 0; s < `HTU_NUM_SETS; s++) begin
    m_ptr[s] = 0;
    for (int w = 0; w < `HTU_NUM_WAYS; w++) begin
      m_half[s][w][0] = `HTU_ST_EMPTY;
      m_half[s][w][1] = `HTU_ST_EMPTY;
    end
  end
endfunction

// -1 when no valid way holds the tag
function automatic int model_hit_way(int set, logic [21:0] tag);
  for (int w = 0; w < `HTU_NUM_WAYS; w++) begin
    if ((m_half[set][w][0] != `HTU_ST_EMPTY || m_half[set][w][1] != `HTU_ST_EMPTY)
        && m_tag[set][w] == tag) begin
      return w;
    end
  end
  return -1;
endfunction

// fills the expected fields of a row from the current model state
function automatic row_t model_expect(row_t r);
  row_t        e;
  int          set;
  int          off;
  int          hw;
  logic [21:0] tag;
  e   = r;
  set = r.addr[`HTU_INDEX_MSB:`HTU_INDEX_LSB];
  off = r.addr[`HTU_OFFSET_BIT];
  tag = r.addr[`HTU_TAG_MSB:`HTU_TAG_LSB];
  hw  = model_hit_way(set, tag);
  e.way      = (hw >= 0) ? hw : m_ptr[set];
  e.linefill = !r.write && (hw < 0 || m_half[set][hw][off] == `HTU_ST_EMPTY);
  e.evict    = (hw < 0) && (m_half[set][e.way][0] == `HTU_ST_DIRTY
                            || m_half[set][e.way][1] == `HTU_ST_DIRTY);
  e.allow    = r.issue_allow && (!(e.linefill || e.evict) || r.bus_allow);
  e.awaddr   = {m_tag[set][e.way], r.addr[`HTU_BANK_MSB:`HTU_BANK_LSB], 3'(set)};
  return e;
endfunction

function automatic void model_update(row_t e);
  int          set;
  int          off;
  logic [21:0] tag;
  set = e.addr[`HTU_INDEX_MSB:`HTU_INDEX_LSB];
  off = e.addr[`HTU_OFFSET_BIT];
  tag = e.addr[`HTU_TAG_MSB:`HTU_TAG_LSB];
  if (e.allow) begin
    // allocation clears both halves first
    if (model_hit_way(set, tag) < 0) begin
      m_tag[set][e.way]     = tag;
      m_half[set][e.way][0] = `HTU_ST_EMPTY;
      m_half[set][e.way][1] = `HTU_ST_EMPTY;
      m_ptr[set]            = (m_ptr[set] + 1) % `HTU_NUM_WAYS;
    end
    if (e.write) begin
      m_half[set][e.way][off] = `HTU_ST_DIRTY;
    end else if (m_half[set][e.way][off] == `HTU_ST_EMPTY) begin
      m_half[set][e.way][off] = `HTU_ST_CLEAN;
    end
  end
endfunction

`endif

// ==== dv/htu_tb.sv ====
`timescale 1ns/10ps
`include "htu_settings.svh"

module htu_tb import htu_pkg::*; ();

  typedef struct {
    string       name;
    logic [1:0]  ch_id;
    logic        write;
    logic [31:0] addr;
    logic [7:0]  wbuf_id;
    logic        issue_allow;
    logic        bus_allow;
    bit          use_model;
    int          way;
    logic        linefill;
    logic        evict;
    logic        allow;
    logic [26:0] awaddr;
  } row_t;

  `include "htu_tb_model.svh"

  localparam logic [1:0] BANK = 2'b10;
  localparam logic [21:0] TAG_A = 22'h0a5a5;
  localparam logic [21:0] TAG_B = 22'h13c00;
  localparam logic [21:0] TAG_C = 22'h3f001;

  logic         clk;
  logic         reset_i;
  logic         req_valid;
  htu_req_t     req;
  logic         req_allow_in;
  logic         issue_valid;
  htu_issue_t   issue;
  logic         issue_allow_in;
  logic         ar_valid;
  logic         aw_valid;
  htu_bus_req_t bus_req;
  logic         bus_allow_in;

  row_t table_q [$];
  int   cycle_limit;
  int   cycles;

  htu_top uut (
    .clk_i            (clk),
    .reset_i          (reset_i),
    .req_valid_i      (req_valid),
    .req_i            (req),
    .req_allow_in_o   (req_allow_in),
    .issue_valid_o    (issue_valid),
    .issue_o          (issue),
    .issue_allow_in_i (issue_allow_in),
    .ar_valid_o       (ar_valid),
    .aw_valid_o       (aw_valid),
    .bus_req_o        (bus_req),
    .bus_allow_in_i   (bus_allow_in)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic void add_row(string name, bit wr, logic [21:0] tag, logic [2:0] idx,
                                  bit off, bit ia, bit ba, int way, bit lf, bit ev, bit al,
                                  logic [26:0] aw, bit from_model = 1'b0);
    row_t r;
    r.name        = name;
    r.ch_id       = 2'($urandom);
    r.write       = wr;
    r.addr        = {tag, BANK, idx, off, 4'h0};
    r.wbuf_id     = 8'($urandom);
    r.issue_allow = ia;
    r.bus_allow   = ba;
    r.use_model   = from_model;
    r.way         = way;
    r.linefill    = lf;
    r.evict       = ev;
    r.allow       = al;
    r.awaddr      = aw;
    table_q.push_back(r);
  endfunction

  // --------------------------------------------------------------------------
  // stimulus table
  // --------------------------------------------------------------------------
  function automatic void build_table();
    add_row("rd_miss_empty", 0, TAG_A, 1, 0, 1, 1, 0, 1, 0, 1, '0);
    add_row("rd_hit_same", 0, TAG_A, 1, 0, 1, 1, 0, 0, 0, 1, '0);
    add_row("rd_half_empty", 0, TAG_A, 1, 1, 1, 1, 0, 1, 0, 1, '0);
    add_row("rd_half_filled", 0, TAG_A, 1, 1, 1, 1, 0, 0, 0, 1, '0);
    add_row("wr_miss_alloc", 1, TAG_B, 1, 0, 1, 1, 1, 0, 0, 1, '0);
    add_row("wr_hit_other", 1, TAG_B, 1, 1, 1, 1, 1, 0, 0, 1, '0);
    add_row("wr_hit_again", 1, TAG_B, 1, 0, 1, 1, 1, 0, 0, 1, '0);
    for (int w = 0; w < `HTU_NUM_WAYS; w++) begin
      add_row($sformatf("wr_fill_way%0d", w), 1, 22'h200 + w, 3, w % 2, 1, 1, w, 0, 0, 1, '0);
    end
    // set 3 is full, victims are dirty from here on
    add_row("wr_evict_way0", 1, 22'h208, 3, 0, 1, 1, 0, 0, 1, 1, {22'h200, BANK, 3'd3});
    add_row("rd_evict_way1", 0, 22'h209, 3, 1, 1, 1, 1, 1, 1, 1, {22'h201, BANK, 3'd3});
    add_row("rd_evicted_tag", 0, 22'h200, 3, 0, 1, 1, 2, 1, 1, 1, {22'h202, BANK, 3'd3});
    add_row("issue_stall", 1, 22'h20a, 3, 0, 0, 1, 3, 0, 1, 0, {22'h203, BANK, 3'd3});
    add_row("issue_retry", 1, 22'h20a, 3, 0, 1, 1, 3, 0, 1, 1, {22'h203, BANK, 3'd3});
    add_row("bus_stall", 0, TAG_C, 5, 0, 1, 0, 0, 1, 0, 0, '0);
    add_row("bus_retry", 0, TAG_C, 5, 0, 1, 1, 0, 1, 0, 1, '0);
    for (int i = 0; i < 40; i++) begin
      add_row($sformatf("rand_%0d", i), $urandom % 2, 22'h300 + $urandom % 10,
              6 + $urandom % 2, $urandom % 2, ($urandom % 4) != 0, ($urandom % 4) != 0,
              0, 0, 0, 0, '0, 1'b1);
    end
  endfunction

  task automatic drive_row(input row_t r, input logic valid);
    req_valid      = valid;
    req.ch_id      = r.ch_id;
    req.write      = r.write;
    req.addr       = htu_addr_u'(r.addr[31:4]);
    req.wbuf_id    = r.wbuf_id;
    issue_allow_in = r.issue_allow;
    bus_allow_in   = r.bus_allow;
  endtask

  task automatic check_value(input string row, input string what, input logic [31:0] exp,
                             input logic [31:0] act, inout int bad);
    assert (act === exp) else begin
      $display("Mismatch %s %s: expected %0h, actual %0h", row, what, exp, act);
      bad++;
    end
  endtask

  task automatic check_row(input row_t r, inout int bad);
    logic [31:0] pass_exp;
    logic [31:0] pass_act;
    int          idx;
    pass_exp = {r.ch_id, r.write, r.addr[`HTU_INDEX_MSB:`HTU_INDEX_LSB],
                r.addr[`HTU_OFFSET_BIT], r.wbuf_id};
    pass_act = {issue.ch_id, issue.write, issue.set, issue.offset, issue.wbuf_id};
    idx      = r.addr[`HTU_INDEX_MSB:`HTU_INDEX_LSB];
    check_value(r.name, "way", r.way, issue.way, bad);
    check_value(r.name, "need_linefill", r.linefill, issue.need_linefill, bad);
    check_value(r.name, "need_evict", r.evict, issue.need_evict, bad);
    check_value(r.name, "req_allow_in", r.allow, req_allow_in, bad);
    check_value(r.name, "issue_valid", !(r.linefill || r.evict) || r.bus_allow,
                issue_valid, bad);
    check_value(r.name, "ar_valid", r.linefill && r.issue_allow, ar_valid, bad);
    check_value(r.name, "aw_valid", r.evict && r.issue_allow, aw_valid, bad);
    check_value(r.name, "passthrough", pass_exp, pass_act, bad);
    // half states of the reported way, before this request updates them
    check_value(r.name, "off0_state", m_half[idx][r.way][0], issue.off0_state, bad);
    check_value(r.name, "off1_state", m_half[idx][r.way][1], issue.off1_state, bad);
    check_value(r.name, "bus_set", idx, bus_req.set, bad);
    check_value(r.name, "bus_way", r.way, bus_req.way, bad);
    if (r.linefill) begin
      check_value(r.name, "araddr", r.addr[31:5], bus_req.araddr, bad);
    end
    if (r.evict) begin
      check_value(r.name, "awaddr", r.awaddr, bus_req.awaddr, bad);
    end
  endtask

  task automatic check_idle(input string name, inout int bad);
    check_value(name, "issue_valid", 1'b0, issue_valid, bad);
    check_value(name, "ar_valid", 1'b0, ar_valid, bad);
    check_value(name, "aw_valid", 1'b0, aw_valid, bad);
  endtask

  task automatic report_test(input string name, input int bad, inout int n_pass,
                             inout int n_fail);
    $display("%-16s %s", name, (bad == 0) ? "ok" : "failed");
    if (bad == 0) begin
      n_pass++;
    end else begin
      n_fail++;
    end
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial begin
    row_t r;
    row_t e;
    int   bad;
    int   n_pass;
    int   n_fail;
    void'($urandom(32'h65fe36dd));
    n_pass = 0;
    n_fail = 0;
    build_table();
    cycle_limit    = 10 * table_q.size() + 8;
    reset_i        = 1'b1;
    req_valid      = 1'b0;
    req            = '0;
    issue_allow_in = 1'b0;
    bus_allow_in   = 1'b0;
    model_reset();
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;
    // first request held back, nothing may issue or update
    drive_row(table_q[0], 1'b0);
    #1;
    bad = 0;
    check_idle("idle_after_reset", bad);
    report_test("idle_after_reset", bad, n_pass, n_fail);
    @(negedge clk);
    foreach (table_q[i]) begin
      r = table_q[i];
      drive_row(r, 1'b1);
      // sample well before the rising edge
      #1;
      bad = 0;
      e   = model_expect(r);
      if (r.use_model) begin
        r = e;
      end else begin
        assert (r.way == e.way && r.linefill == e.linefill && r.evict == e.evict
                && r.allow == e.allow && (!e.evict || r.awaddr == e.awaddr))
        else begin
          $display("Table row %s does not match the reference model", r.name);
          bad++;
        end
      end
      check_row(r, bad);
      model_update(e);
      report_test(r.name, bad, n_pass, n_fail);
      @(negedge clk);
    end
    req_valid = 1'b0;
    $display("%0d tests run, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
    if (n_fail == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    cycles = 0;
    @(posedge clk);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the table did not finish", cycles);
    $display("Checks failed");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+verilog
+incdir+dv
verilog/htu_pkg.sv
verilog/htu_set_entry.sv
verilog/htu_set_array.sv
verilog/htu_ctrl.sv
verilog/htu_top.sv
dv/htu_tb.sv
